// ==== source/ex_stage_pkg.sv ====
// Shared widths, ALU function codes and multiplier depth for the execute stage; compile it first
`default_nettype none

package ex_stage_pkg;

	//////////////////////////////
	// Datapath widths
	//////////////////////////////

	// Operand and result word
	localparam int xlen = 64;

	// Physical register tag carried with every result
	localparam int prf_idx_w = 6;

	// Reorder buffer slot of the instruction
	localparam int rob_idx_w = 5;

	//////////////////////////////
	// Multiplier
	//////////////////////////////

	// Pipeline depth, one slice of the multiplier operand per stage
	localparam int mult_stages = 4;
	localparam int mult_chunk_w = xlen / mult_stages;

	//////////////////////////////
	// ALU function codes
	//////////////////////////////

	// Shifts take their amount from the low 6 bits of b
	// Both compares return 1 or 0 and drive the branch bit
	typedef enum logic [4:0] {
		alu_add   = 5'h00,
		alu_sub   = 5'h01,
		alu_and   = 5'h02,
		alu_or    = 5'h03,
		alu_xor   = 5'h04,
		alu_sll   = 5'h05,
		alu_srl   = 5'h06,
		alu_cmpeq = 5'h07,
		alu_cmplt = 5'h08,
		alu_mulq  = 5'h09,
		alu_nop   = 5'h1f
	} alu_op_t;

endpackage

`default_nettype wire

// ==== source/fu_result_if.sv ====
// Held result of one functional unit and its CDB grant; one instance per unit in the stage
`default_nettype none

interface fu_result_if;
	import ex_stage_pkg::*;

	// Result held by the unit until granted
	logic                 done_reg;
	logic [xlen-1:0]      value;
	logic [prf_idx_w-1:0] pdest;
	logic [rob_idx_w-1:0] rob_idx;
	logic                 br_result;

	// Bus grant, a level seen at the clock edge
	logic gnt;

	modport unit (
		output done_reg, value, pdest, rob_idx, br_result,
		input  gnt
	);

	modport arbiter (
		input  done_reg, value, pdest, rob_idx, br_result,
		output gnt
	);

endinterface

`default_nettype wire

// ==== source/issue_router.sv ====
// Steers the issued instruction to the ALU or the multiplier; used inside the execute stage
`default_nettype none

module issue_router (
	input  logic                                   issue_valid,
	input  ex_stage_pkg::alu_op_t                  op,
	input  logic [ex_stage_pkg::xlen-1:0]          a,
	input  logic [ex_stage_pkg::xlen-1:0]          b,
	input  logic [ex_stage_pkg::prf_idx_w-1:0]     pdest,
	input  logic [ex_stage_pkg::rob_idx_w-1:0]     rob_idx,
	input  logic                                   alu_free,
	input  logic                                   mult_free,
	output logic                                   alu_issue,
	output logic                                   mult_issue
);
	import ex_stage_pkg::*;

	//////////////////////////////
	// Instruction class decode
	//////////////////////////////

	// Multiplies go to the pipelined unit, everything else but nop to the ALU
	always_comb begin
		alu_issue = 1'b0;
		mult_issue = 1'b0;
		if (issue_valid) begin
			if (op == alu_mulq) begin
				mult_issue = 1'b1;
			end else if (op != alu_nop) begin
				alu_issue = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Issue side checks
	//////////////////////////////

	// Issue side has to wait for the free level of the target unit
	always_comb begin
		assert final (!(alu_issue && !alu_free) && !(mult_issue && !mult_free))
		else $error("issue to a busy functional unit");
	end

	// Operands and tags are fanned out to both units unchanged
	always_comb begin
		assert final (!(alu_issue || mult_issue) || !$isunknown({a, b, pdest, rob_idx}))
		else $error("issued instruction carries unknown operands or tags");
	end

endmodule

`default_nettype wire

// ==== source/alu_unit.sv ====
// Single-cycle integer ALU with a result register held until the CDB grant; one per stage
`default_nettype none

module alu_unit (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   issue,
	input  ex_stage_pkg::alu_op_t                  op,
	input  logic [ex_stage_pkg::xlen-1:0]          a,
	input  logic [ex_stage_pkg::xlen-1:0]          b,
	input  logic [ex_stage_pkg::prf_idx_w-1:0]     pdest,
	input  logic [ex_stage_pkg::rob_idx_w-1:0]     rob_idx,
	fu_result_if.unit                              res,
	output logic                                   free
);
	import ex_stage_pkg::*;

	logic [xlen-1:0] result;
	logic            br_next;
	logic            hold;

	//////////////////////////////
	// Function
	//////////////////////////////

	always_comb begin
		result = '0;
		br_next = 1'b0;
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_sll: result = a << b[5:0];
			alu_srl: result = a >> b[5:0];
			alu_cmpeq: begin
				br_next = (a == b);
				result = xlen'(br_next);
			end
			alu_cmplt: begin
				br_next = ($signed(a) < $signed(b));
				result = xlen'(br_next);
			end
			// Multiply and nop never reach this unit
			default: result = '0;
		endcase
	end

	//////////////////////////////
	// Result register
	//////////////////////////////

	// Busy while an ungranted result sits in the register
	assign hold = res.done_reg && !res.gnt;
	assign free = !hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			res.done_reg <= 1'b0;
		end else if (issue) begin
			res.done_reg <= 1'b1;
		end else if (res.gnt) begin
			res.done_reg <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			res.value <= result;
			res.br_result <= br_next;
			res.pdest <= pdest;
			res.rob_idx <= rob_idx;
		end
	end

	// A new instruction may only land once the held one has gone out on the bus
	assert property (@(posedge clk) disable iff (reset) issue |-> !hold)
	else $error("ALU result register loaded while holding an ungranted result");

endmodule

`default_nettype wire

// ==== source/mult_unit.sv ====
// Pipelined 64-bit multiplier that freezes while its output result waits for the CDB; one per stage
`default_nettype none

module mult_unit (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   issue,
	input  logic [ex_stage_pkg::xlen-1:0]          a,
	input  logic [ex_stage_pkg::xlen-1:0]          b,
	input  logic [ex_stage_pkg::prf_idx_w-1:0]     pdest,
	input  logic [ex_stage_pkg::rob_idx_w-1:0]     rob_idx,
	fu_result_if.unit                              res,
	output logic                                   free
);
	import ex_stage_pkg::*;

	localparam int last = mult_stages - 1;

	// Per-stage state, the last stage is the held result
	logic [mult_stages-1:0] valid;
	logic [xlen-1:0]        prod   [mult_stages];
	logic [prf_idx_w-1:0]   tag    [mult_stages];
	logic [rob_idx_w-1:0]   rob    [mult_stages];

	// Shifted operands still needed by the later stages
	logic [xlen-1:0]        mcand  [mult_stages-1];
	logic [xlen-1:0]        mplier [mult_stages-1];

	logic stall;

	//////////////////////////////
	// Stall and free
	//////////////////////////////

	// Whole pipe freezes behind an ungranted output
	assign stall = valid[last] && !res.gnt;
	assign free = !stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (!stall) begin
			valid <= {valid[mult_stages-2:0], issue};
		end
	end

	//////////////////////////////
	// Partial product stages
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!stall) begin
			// First slice of b
			prod[0] <= a * xlen'(b[mult_chunk_w-1:0]);
			mcand[0] <= a << mult_chunk_w;
			mplier[0] <= b >> mult_chunk_w;
			tag[0] <= pdest;
			rob[0] <= rob_idx;

			// Each later stage adds the next slice; only the low word is kept
			for (int i = 1; i < mult_stages; i++) begin
				prod[i] <= prod[i-1] + mcand[i-1] * xlen'(mplier[i-1][mult_chunk_w-1:0]);
				tag[i] <= tag[i-1];
				rob[i] <= rob[i-1];
			end

			for (int i = 1; i < mult_stages - 1; i++) begin
				mcand[i] <= mcand[i-1] << mult_chunk_w;
				mplier[i] <= mplier[i-1] >> mult_chunk_w;
			end
		end
	end

	//////////////////////////////
	// Held result
	//////////////////////////////

	assign res.done_reg = valid[last];
	assign res.value = prod[last];
	assign res.pdest = tag[last];
	assign res.rob_idx = rob[last];
	assign res.br_result = 1'b0;

	// A multiply may only enter while the pipe moves
	assert property (@(posedge clk) disable iff (reset) issue |-> free)
	else $error("multiply issued while the pipeline is stalled");

endmodule

`default_nettype wire

// ==== source/cdb_arbiter.sv ====
// Fixed-priority grant and multiplexer of the common data bus; multiplier wins over the ALU
`default_nettype none

module cdb_arbiter (
	fu_result_if.arbiter                           mult_res,
	fu_result_if.arbiter                           alu_res,
	output logic                                   cdb_valid,
	output logic [ex_stage_pkg::prf_idx_w-1:0]     cdb_tag,
	output logic [ex_stage_pkg::xlen-1:0]          cdb_value,
	output logic [ex_stage_pkg::rob_idx_w-1:0]     cdb_rob_idx,
	output logic                                   cdb_br_result
);

	//////////////////////////////
	// Grant
	//////////////////////////////

	// Multiplier first, since its stall backs up the whole pipe
	assign mult_res.gnt = mult_res.done_reg;
	assign alu_res.gnt = alu_res.done_reg && !mult_res.done_reg;

	//////////////////////////////
	// Bus multiplexer
	//////////////////////////////

	always_comb begin
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		cdb_rob_idx = '0;
		cdb_br_result = 1'b0;
		if (mult_res.gnt) begin
			cdb_valid = 1'b1;
			cdb_tag = mult_res.pdest;
			cdb_value = mult_res.value;
			cdb_rob_idx = mult_res.rob_idx;
			cdb_br_result = mult_res.br_result;
		end else if (alu_res.gnt) begin
			cdb_valid = 1'b1;
			cdb_tag = alu_res.pdest;
			cdb_value = alu_res.value;
			cdb_rob_idx = alu_res.rob_idx;
			cdb_br_result = alu_res.br_result;
		end
	end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
// Top of the execute stage; connects the router, the two functional units and the CDB arbiter
`default_nettype none

module ex_stage (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   issue_valid,
	input  ex_stage_pkg::alu_op_t                  op,
	input  logic [ex_stage_pkg::xlen-1:0]          a,
	input  logic [ex_stage_pkg::xlen-1:0]          b,
	input  logic [ex_stage_pkg::prf_idx_w-1:0]     pdest,
	input  logic [ex_stage_pkg::rob_idx_w-1:0]     rob_idx,
	output logic                                   alu_free,
	output logic                                   mult_free,
	output logic                                   cdb_valid,
	output logic [ex_stage_pkg::prf_idx_w-1:0]     cdb_tag,
	output logic [ex_stage_pkg::xlen-1:0]          cdb_value,
	output logic [ex_stage_pkg::rob_idx_w-1:0]     cdb_rob_idx,
	output logic                                   cdb_br_result
);

	logic alu_issue;
	logic mult_issue;

	// Result links from each unit to the arbiter
	fu_result_if alu_res ();
	fu_result_if mult_res ();

	//////////////////////////////
	// Issue
	//////////////////////////////

	issue_router issue_router_inst (
		.issue_valid (issue_valid),
		.op          (op),
		.a           (a),
		.b           (b),
		.pdest       (pdest),
		.rob_idx     (rob_idx),
		.alu_free    (alu_free),
		.mult_free   (mult_free),
		.alu_issue   (alu_issue),
		.mult_issue  (mult_issue)
	);

	//////////////////////////////
	// Functional units
	//////////////////////////////

	alu_unit alu_unit_inst (
		.clk     (clk),
		.reset   (reset),
		.issue   (alu_issue),
		.op      (op),
		.a       (a),
		.b       (b),
		.pdest   (pdest),
		.rob_idx (rob_idx),
		.res     (alu_res.unit),
		.free    (alu_free)
	);

	mult_unit mult_unit_inst (
		.clk     (clk),
		.reset   (reset),
		.issue   (mult_issue),
		.a       (a),
		.b       (b),
		.pdest   (pdest),
		.rob_idx (rob_idx),
		.res     (mult_res.unit),
		.free    (mult_free)
	);

	// CDB
	cdb_arbiter cdb_arbiter_inst (
		.mult_res      (mult_res.arbiter),
		.alu_res       (alu_res.arbiter),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.cdb_rob_idx   (cdb_rob_idx),
		.cdb_br_result (cdb_br_result)
	);

endmodule

`default_nettype wire

// ==== testbench/ex_stage_model.svh ====
// Reference model and scoreboard of the execute stage; included inside the testbench module

// Expected CDB entry per rob index
bit                   pending       [1 << rob_idx_w];
logic [xlen-1:0]      exp_value     [1 << rob_idx_w];
logic [prf_idx_w-1:0] exp_tag       [1 << rob_idx_w];
logic                 exp_br        [1 << rob_idx_w];
bit                   exp_from_mult [1 << rob_idx_w];

int pending_count = 0;
int mults_pending = 0;
int max_mults = 0;
int alu_broadcasts = 0;
int mult_broadcasts = 0;

// Result and branch bit of one op, straight from the op rules
task automatic expected_result(input alu_op_t op_in, input logic [xlen-1:0] a_in,
	input logic [xlen-1:0] b_in, output logic [xlen-1:0] value, output logic br);
	logic [2*xlen-1:0] full;
	value = '0;
	br = 1'b0;
	case (op_in)
		alu_add: value = a_in + b_in;
		alu_sub: value = a_in - b_in;
		alu_and: value = a_in & b_in;
		alu_or:  value = a_in | b_in;
		alu_xor: value = a_in ^ b_in;
		alu_sll: value = a_in << b_in[5:0];
		alu_srl: value = a_in >> b_in[5:0];
		alu_cmpeq: br = (a_in == b_in);
		// Signed compare from the sign bits, unsigned order when the signs agree
		alu_cmplt: br = (a_in[xlen-1] != b_in[xlen-1]) ? a_in[xlen-1] : (a_in < b_in);
		alu_mulq: begin
			full = {{xlen{1'b0}}, a_in} * {{xlen{1'b0}}, b_in};
			value = full[xlen-1:0];
		end
		default: value = '0;
	endcase
	if (op_in == alu_cmpeq || op_in == alu_cmplt) begin
		value = {{(xlen-1){1'b0}}, br};
	end
endtask

task automatic record_issue(input alu_op_t op_in, input logic [xlen-1:0] a_in,
	input logic [xlen-1:0] b_in, input logic [prf_idx_w-1:0] tag,
	input logic [rob_idx_w-1:0] rob);
	logic [xlen-1:0] value;
	logic br;
	assert (!pending[rob])
	else report_problem($sformatf("rob index %0d issued again while still pending", rob));
	expected_result(op_in, a_in, b_in, value, br);
	pending[rob] = 1'b1;
	exp_value[rob] = value;
	exp_tag[rob] = tag;
	exp_br[rob] = br;
	exp_from_mult[rob] = (op_in == alu_mulq);
	pending_count++;
	if (op_in == alu_mulq) begin
		mults_pending++;
		if (mults_pending > max_mults) max_mults = mults_pending;
	end
endtask

task automatic check_broadcast(input logic [prf_idx_w-1:0] tag, input logic [xlen-1:0] value,
	input logic [rob_idx_w-1:0] rob, input logic br);
	assert (pending[rob])
	else report_problem($sformatf("CDB broadcast for rob index %0d, which is not pending", rob));
	assert (tag == exp_tag[rob])
	else report_mismatch("cdb_tag", xlen'(tag), xlen'(exp_tag[rob]));
	assert (value == exp_value[rob])
	else report_mismatch("cdb_value", value, exp_value[rob]);
	assert (br == exp_br[rob])
	else report_mismatch("cdb_br_result", xlen'(br), xlen'(exp_br[rob]));
	pending[rob] = 1'b0;
	pending_count--;
	if (exp_from_mult[rob]) begin
		mults_pending--;
		mult_broadcasts++;
	end else begin
		alu_broadcasts++;
	end
endtask

// ==== testbench/ex_stage_tb.sv ====
// Testbench for the execute stage; random issue from a fixed seed, CDB checked against a model
`default_nettype none

module ex_stage_tb;
	import ex_stage_pkg::*;

	localparam int stim_cycles = 400;
	localparam int drain_limit = 100;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 issue_valid;
	alu_op_t              op;
	logic [xlen-1:0]      a;
	logic [xlen-1:0]      b;
	logic [prf_idx_w-1:0] pdest;
	logic [rob_idx_w-1:0] rob_idx;
	logic                 alu_free;
	logic                 mult_free;
	logic                 cdb_valid;
	logic [prf_idx_w-1:0] cdb_tag;
	logic [xlen-1:0]      cdb_value;
	logic [rob_idx_w-1:0] cdb_rob_idx;
	logic                 cdb_br_result;

	// Next instruction, picked at the falling edge
	logic                 next_valid;
	alu_op_t              next_op;
	logic [xlen-1:0]      next_a;
	logic [xlen-1:0]      next_b;
	logic [prf_idx_w-1:0] next_pdest;

	logic driven_alu;
	int   issued_count;
	int   stall_cycles;
	int   waited;

	ex_stage ex_stage_inst (
		.clk           (clk),
		.reset         (reset),
		.issue_valid   (issue_valid),
		.op            (op),
		.a             (a),
		.b             (b),
		.pdest         (pdest),
		.rob_idx       (rob_idx),
		.alu_free      (alu_free),
		.mult_free     (mult_free),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_value     (cdb_value),
		.cdb_rob_idx   (cdb_rob_idx),
		.cdb_br_result (cdb_br_result)
	);

	always #2 clk = ~clk;

	`include "ex_stage_model.svh"

	//////////////////////////////
	// Failure reporting
	//////////////////////////////

	task automatic stop_with_failure();
		$display("Checks failed");
		$fatal(1, "stopped at the first failed check");
	endtask

	task automatic report_mismatch(input string sig, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		$display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		stop_with_failure();
	endtask

	//////////////////////////////
	// Stimulus and observation
	//////////////////////////////

	// Quiet bus and both units free
	task automatic check_idle_outputs();
		assert (cdb_valid === 1'b0) else report_mismatch("cdb_valid", xlen'(cdb_valid), xlen'(0));
		assert (alu_free === 1'b1) else report_mismatch("alu_free", xlen'(alu_free), xlen'(1));
		assert (mult_free === 1'b1) else report_mismatch("mult_free", xlen'(mult_free), xlen'(1));
	endtask

	task automatic observe_cdb();
		if (cdb_valid) begin
			check_broadcast(cdb_tag, cdb_value, cdb_rob_idx, cdb_br_result);
		end
	endtask

	task automatic pick_next();
		int unsigned roll;
		roll = $urandom % 100;
		next_a = {$urandom, $urandom};
		next_b = {$urandom, $urandom};
		next_pdest = prf_idx_w'($urandom);
		if (roll < 10) begin
			next_op = alu_nop;
		end else if (roll < 45) begin
			next_op = alu_mulq;
		end else begin
			case ($urandom % 9)
				0: next_op = alu_add;
				1: next_op = alu_sub;
				2: next_op = alu_and;
				3: next_op = alu_or;
				4: next_op = alu_xor;
				5: next_op = alu_sll;
				6: next_op = alu_srl;
				7: next_op = alu_cmpeq;
				default: next_op = alu_cmplt;
			endcase
		end
		// Equal operands now and then so cmpeq also returns 1
		if (next_op == alu_cmpeq && roll[0]) next_b = next_a;
		// The multiplier always wins the bus, so its free level carries over
		if (next_op == alu_mulq && !mult_free) next_op = alu_nop;
		// ALU is only sure to be free if it was free and got nothing new last cycle
		if (next_op != alu_mulq && next_op != alu_nop && (!alu_free || driven_alu)) begin
			next_op = alu_nop;
		end
		next_valid = (next_op != alu_nop) ? 1'b1 : 1'($urandom % 2);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'h4a40_fb3c));
		reset = 1'b1;
		issue_valid = 1'b0;
		op = alu_nop;
		a = '0;
		b = '0;
		pdest = '0;
		rob_idx = '0;
		driven_alu = 1'b0;
		issued_count = 0;
		stall_cycles = 0;

		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			if (i == 9) reset <= 1'b0;
			@(negedge clk);
			check_idle_outputs();
		end
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_idle_outputs();
		end

		pick_next();
		for (int cycle = 0; cycle < stim_cycles; cycle++) begin
			@(posedge clk);
			issue_valid <= next_valid;
			op <= next_op;
			a <= next_a;
			b <= next_b;
			pdest <= next_pdest;
			rob_idx <= rob_idx_w'(issued_count);
			driven_alu = next_valid && next_op != alu_mulq && next_op != alu_nop;
			if (next_valid && next_op != alu_nop) begin
				record_issue(next_op, next_a, next_b, next_pdest, rob_idx_w'(issued_count));
				issued_count++;
			end
			@(negedge clk);
			observe_cdb();
			if (!alu_free) stall_cycles++;
			pick_next();
		end

		// Drain whatever is still in flight
		@(posedge clk);
		issue_valid <= 1'b0;
		op <= alu_nop;
		waited = 0;
		while (pending_count != 0 && waited < drain_limit) begin
			@(negedge clk);
			observe_cdb();
			waited++;
		end

		if (pending_count == 0) begin
			assert (max_mults >= 2) else report_problem("never more than one multiply in flight");
			assert (stall_cycles > 0) else report_problem("the ALU never waited for the CDB");
			$display("Issued %0d, ALU results %0d, multiply results %0d, ALU stall cycles %0d",
				issued_count, alu_broadcasts, mult_broadcasts, stall_cycles);
			$display("All checks passed");
			$finish;
		end else begin
			report_problem($sformatf("timeout with %0d results never seen on the CDB",
				pending_count));
		end
	end

endmodule

`default_nettype wire

// ==== ex_stage.f ====
+incdir+testbench
source/ex_stage_pkg.sv
source/fu_result_if.sv
source/issue_router.sv
source/alu_unit.sv
source/mult_unit.sv
source/cdb_arbiter.sv
source/ex_stage.sv
testbench/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the execute stage testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module ex_stage_tb -f ex_stage.f -Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ex_stage_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
	echo "Simulation reported failures"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
